// File: src/lpc_pkg.sv
`default_nettype none

package lpc_pkg;

	////////////////////////////////////////
	// Recursion sizes
	////////////////////////////////////////

	localparam int LPC_ORDER   = 10;
	localparam int N_LAGS      = LPC_ORDER + 1;
	localparam int LAG_IDX_W   = 4;
	localparam int WORD_W      = 32;
	localparam int OUT_W       = 16;
	localparam int COEF_FRAC   = 27;
	localparam int OUT_FRAC    = 12;
	localparam int N_RC_OUT    = 2;
	localparam int N_OUT_WORDS = N_LAGS + N_RC_OUT;

	// 1.0 in Q12
	localparam logic [OUT_W-1:0] A0_ONE = 16'd4096;

	// Largest |k| in Q31, 32750 in Q15
	localparam logic [WORD_W-1:0] K_LIMIT = 32'd32750 << 16;

	////////////////////////////////////////
	// Frame and result types
	////////////////////////////////////////

	typedef struct packed {
		logic [N_LAGS-1:0][WORD_W-1:0] r;
	} lag_frame_t;

	typedef struct packed {
		logic wr_en;
		logic [LAG_IDX_W-1:0] idx;
		logic signed [WORD_W-1:0] value;
	} coef_wr_t;

	typedef struct packed {
		logic [N_LAGS-1:0][OUT_W-1:0] a;
		logic [N_RC_OUT-1:0][OUT_W-1:0] rc;
	} lpc_result_t;

	typedef struct packed {
		logic is_rc;
		logic [LAG_IDX_W-1:0] idx;
		logic [OUT_W-1:0] value;
	} out_word_t;

endpackage

`default_nettype wire

// File: src/ld_input_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module ld_input_buffer (
	input logic clock,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic signed [lpc_pkg::WORD_W-1:0] in_data,
	output logic frame_valid,
	input logic frame_ready,
	output lpc_pkg::lag_frame_t frame
);

	logic [lpc_pkg::LAG_IDX_W-1:0] count;

	// Closed while a full frame waits for the controller
	assign in_ready = !frame_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
			frame_valid <= 1'b0;
		end else begin
			if (in_valid && in_ready) begin
				if (count == lpc_pkg::N_LAGS - 1) begin
					count <= '0;
					frame_valid <= 1'b1;
				end else begin
					count <= count + 1'b1;
				end
			end
			if (frame_valid && frame_ready)
				frame_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready)
			frame.r[count] <= in_data;
	end

endmodule

`default_nettype wire

// File: src/q31_divider.sv
`timescale 1ns/100ps
`default_nettype none

module q31_divider (
	input logic clock,
	input logic reset,
	input logic start,
	input logic [lpc_pkg::WORD_W-1:0] dividend,
	input logic [lpc_pkg::WORD_W-1:0] divisor,
	output logic done,
	output logic [lpc_pkg::WORD_W-1:0] quotient
);

	logic busy;
	logic [$clog2(lpc_pkg::WORD_W)-1:0] count;
	logic [lpc_pkg::WORD_W-1:0] rem;
	logic [lpc_pkg::WORD_W-1:0] dvs;
	logic [lpc_pkg::WORD_W:0] rem_sh;
	logic [lpc_pkg::WORD_W:0] diff;
	logic fits;

	// One trial subtraction per cycle
	assign rem_sh = {rem, 1'b0};
	assign diff = rem_sh - {1'b0, dvs};
	assign fits = rem_sh >= {1'b0, dvs};

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				count <= '1; // 31 fraction bits
			end else if (busy) begin
				count <= count - 1'b1;
				if (count == 1) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			rem <= dividend;
			dvs <= divisor;
			quotient <= '0;
		end else if (busy) begin
			rem <= fits ? diff[lpc_pkg::WORD_W-1:0] : rem_sh[lpc_pkg::WORD_W-1:0];
			quotient <= {quotient[lpc_pkg::WORD_W-2:0], fits};
		end
	end

endmodule

`default_nettype wire

// File: src/ld_coef_bank.sv
`timescale 1ns/100ps
`default_nettype none

module ld_coef_bank (
	input logic clock,
	input logic reset,
	input logic [lpc_pkg::LAG_IDX_W-1:0] rd_idx_a,
	input logic [lpc_pkg::LAG_IDX_W-1:0] rd_idx_b,
	output logic signed [lpc_pkg::WORD_W-1:0] rd_data_a,
	output logic signed [lpc_pkg::WORD_W-1:0] rd_data_b,
	input lpc_pkg::coef_wr_t coef_wr,
	input logic step_commit,
	input logic frame_begin,
	input logic frame_end,
	input logic frame_stable,
	input logic rc_wr_en,
	input logic rc_idx,
	input logic signed [lpc_pkg::WORD_W-1:0] rc_value,
	output lpc_pkg::lpc_result_t result
);

	logic signed [lpc_pkg::WORD_W-1:0] cur [lpc_pkg::N_LAGS];
	logic signed [lpc_pkg::WORD_W-1:0] nxt [lpc_pkg::N_LAGS];
	logic [lpc_pkg::N_RC_OUT-1:0][lpc_pkg::OUT_W-1:0] rc_pend;
	lpc_pkg::lpc_result_t rounded;

	assign rd_data_a = cur[rd_idx_a];
	assign rd_data_b = cur[rd_idx_b];

	always_ff @(posedge clock) begin
		if (frame_begin) begin
			for (int n = 1; n < lpc_pkg::N_LAGS; n++) begin
				cur[n] <= '0;
				nxt[n] <= '0;
			end
			cur[0] <= 1 <<< lpc_pkg::COEF_FRAC;
			nxt[0] <= 1 <<< lpc_pkg::COEF_FRAC;
		end else begin
			if (coef_wr.wr_en)
				nxt[coef_wr.idx] <= coef_wr.value;
			if (step_commit)
				cur <= nxt;
		end
		// k in Q31 kept as Q15
		if (rc_wr_en)
			rc_pend[rc_idx] <= rc_value[lpc_pkg::WORD_W-1 -: lpc_pkg::OUT_W];
	end

	////////////////////////////////////////
	// Q27 to Q12 with rounding
	////////////////////////////////////////

	always_comb begin
		logic signed [lpc_pkg::WORD_W:0] biased;
		logic signed [lpc_pkg::WORD_W:0] shifted;
		rounded.rc = rc_pend;
		rounded.a[0] = lpc_pkg::A0_ONE;
		for (int n = 1; n < lpc_pkg::N_LAGS; n++) begin
			biased = cur[n] + (1 <<< (lpc_pkg::COEF_FRAC - lpc_pkg::OUT_FRAC - 1));
			shifted = biased >>> (lpc_pkg::COEF_FRAC - lpc_pkg::OUT_FRAC);
			rounded.a[n] = shifted[lpc_pkg::OUT_W-1:0];
		end
	end

	// Unstable frame leaves the last good result in place
	always_ff @(posedge clock) begin
		if (reset) begin
			result <= '0;
			result.a[0] <= lpc_pkg::A0_ONE;
		end else if (frame_end && frame_stable) begin
			result <= rounded;
		end
	end

endmodule

`default_nettype wire

// File: src/ld_recursion_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module ld_recursion_ctrl (
	input logic clock,
	input logic reset,
	input logic frame_valid,
	output logic frame_ready,
	input lpc_pkg::lag_frame_t frame,
	output logic div_start,
	output logic [lpc_pkg::WORD_W-1:0] dividend,
	output logic [lpc_pkg::WORD_W-1:0] divisor,
	input logic div_done,
	input logic [lpc_pkg::WORD_W-1:0] quotient,
	output logic [lpc_pkg::LAG_IDX_W-1:0] rd_idx_a,
	output logic [lpc_pkg::LAG_IDX_W-1:0] rd_idx_b,
	input logic signed [lpc_pkg::WORD_W-1:0] rd_data_a,
	input logic signed [lpc_pkg::WORD_W-1:0] rd_data_b,
	output lpc_pkg::coef_wr_t coef_wr,
	output logic step_commit,
	output logic frame_begin,
	output logic frame_end,
	output logic frame_stable,
	output logic rc_wr_en,
	output logic rc_idx,
	output logic signed [lpc_pkg::WORD_W-1:0] rc_value,
	output logic res_valid,
	input logic res_ready
);

	typedef enum logic [3:0] {
		S_IDLE, S_ORDER, S_CORR, S_CHECK, S_DIV, S_UPD, S_ALPHA, S_END, S_RES
	} state_t;

	state_t state;
	logic [lpc_pkg::LAG_IDX_W-1:0] order;
	logic [lpc_pkg::LAG_IDX_W-1:0] term;
	logic stable;
	logic signed [lpc_pkg::WORD_W-1:0] lag [lpc_pkg::N_LAGS];
	logic signed [2*lpc_pkg::WORD_W-1:0] acc;
	logic signed [lpc_pkg::WORD_W-1:0] alpha;
	logic signed [lpc_pkg::WORD_W-1:0] k;

	logic signed [2*lpc_pkg::WORD_W-1:0] acc_sh;
	logic signed [2*lpc_pkg::WORD_W-1:0] corr_prod;
	logic signed [2*lpc_pkg::WORD_W-1:0] upd_prod;
	logic signed [2*lpc_pkg::WORD_W-1:0] ksq_prod;
	logic signed [2*lpc_pkg::WORD_W-1:0] alpha_prod;
	logic signed [lpc_pkg::WORD_W-1:0] t;
	logic signed [lpc_pkg::WORD_W-1:0] ksq;
	logic signed [lpc_pkg::WORD_W-1:0] k_new;
	logic [lpc_pkg::WORD_W-1:0] abs_t;
	logic t_unstable;
	logic k_unstable;

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	// t = acc >> 27, saturated to 32 bits
	assign acc_sh = acc >>> lpc_pkg::COEF_FRAC;
	always_comb begin
		if (acc_sh[2*lpc_pkg::WORD_W-1:lpc_pkg::WORD_W-1] ==
				{(lpc_pkg::WORD_W+1){acc_sh[2*lpc_pkg::WORD_W-1]}})
			t = acc_sh[lpc_pkg::WORD_W-1:0];
		else if (acc_sh[2*lpc_pkg::WORD_W-1])
			t = {1'b1, {(lpc_pkg::WORD_W-1){1'b0}}};
		else
			t = {1'b0, {(lpc_pkg::WORD_W-1){1'b1}}};
	end

	assign abs_t = t[lpc_pkg::WORD_W-1] ? -t : t;
	assign t_unstable = abs_t >= $unsigned(alpha);
	assign k_new = (!t[lpc_pkg::WORD_W-1] && t != 0) ? -$signed(quotient) : $signed(quotient);
	assign k_unstable = quotient > lpc_pkg::K_LIMIT;

	assign corr_prod = lag[term] * rd_data_a;
	assign upd_prod = k * rd_data_a;
	assign ksq_prod = k * k;
	assign ksq = ksq_prod[2*lpc_pkg::WORD_W-2:lpc_pkg::WORD_W-1];
	assign alpha_prod = alpha * ksq;

	assign rd_idx_a = order - term;
	assign rd_idx_b = term;
	assign dividend = abs_t;
	assign divisor = alpha;

	assign frame_ready = state == S_IDLE;
	assign frame_begin = frame_valid && frame_ready;
	assign div_start = state == S_CHECK && !t_unstable;
	assign rc_wr_en = state == S_DIV && div_done && !k_unstable && order <= lpc_pkg::N_RC_OUT;
	assign rc_idx = order == 2;
	assign rc_value = k_new;
	assign step_commit = state == S_ALPHA;
	assign frame_end = state == S_END;
	assign frame_stable = stable;
	assign res_valid = state == S_RES;

	// a_next[j] = a[j] + k*a[i-j], last slot takes k itself
	always_comb begin
		coef_wr.wr_en = state == S_UPD;
		coef_wr.idx = term;
		if (term == order)
			coef_wr.value = k >>> (lpc_pkg::WORD_W - 1 - lpc_pkg::COEF_FRAC);
		else
			coef_wr.value = rd_data_b + upd_prod[2*lpc_pkg::WORD_W-2:lpc_pkg::WORD_W-1];
	end

	////////////////////////////////////////
	// Order sequencer
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			order <= '0;
			term <= '0;
			stable <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (frame_valid) begin
						order <= 1;
						stable <= 1'b1;
						state <= S_ORDER;
					end
				end
				S_ORDER: begin
					term <= 1;
					state <= S_CORR;
				end
				S_CORR: begin
					if (term == order)
						state <= S_CHECK;
					else
						term <= term + 1'b1;
				end
				S_CHECK: begin
					if (t_unstable) begin
						stable <= 1'b0;
						state <= S_END;
					end else begin
						state <= S_DIV;
					end
				end
				S_DIV: begin
					if (div_done) begin
						if (k_unstable) begin
							stable <= 1'b0;
							state <= S_END;
						end else begin
							term <= 1;
							state <= S_UPD;
						end
					end
				end
				S_UPD: begin
					if (term == order)
						state <= S_ALPHA;
					else
						term <= term + 1'b1;
				end
				S_ALPHA: begin
					if (order == lpc_pkg::LPC_ORDER) begin
						state <= S_END;
					end else begin
						order <= order + 1'b1;
						state <= S_ORDER;
					end
				end
				S_END: state <= S_RES;
				S_RES: begin
					if (res_ready)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (frame_valid && frame_ready) begin
			for (int n = 0; n < lpc_pkg::N_LAGS; n++)
				lag[n] <= frame.r[n];
			alpha <= frame.r[0];
		end
		if (state == S_ORDER)
			acc <= 64'(lag[order]) <<< lpc_pkg::COEF_FRAC;
		if (state == S_CORR && term != order)
			acc <= acc + corr_prod;
		if (state == S_DIV && div_done)
			k <= k_new;
		if (state == S_ALPHA)
			alpha <= alpha - alpha_prod[2*lpc_pkg::WORD_W-2:lpc_pkg::WORD_W-1];
	end

endmodule

`default_nettype wire

// File: src/ld_output_stream.sv
`timescale 1ns/100ps
`default_nettype none

module ld_output_stream (
	input logic clock,
	input logic reset,
	input logic res_valid,
	output logic res_ready,
	input lpc_pkg::lpc_result_t result,
	output logic out_valid,
	input logic out_ready,
	output lpc_pkg::out_word_t out_data
);

	lpc_pkg::lpc_result_t snap;
	logic [lpc_pkg::LAG_IDX_W-1:0] count;
	logic busy;
	logic rc_sel;

	assign res_ready = !busy;
	assign out_valid = busy;

	// a[0..10] first, then rc[0..1]
	assign rc_sel = count != lpc_pkg::N_LAGS;
	always_comb begin
		out_data.is_rc = count >= lpc_pkg::N_LAGS;
		if (out_data.is_rc) begin
			out_data.idx = {{(lpc_pkg::LAG_IDX_W-1){1'b0}}, rc_sel};
			out_data.value = snap.rc[rc_sel];
		end else begin
			out_data.idx = count;
			out_data.value = snap.a[count];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
		end else if (res_valid && res_ready) begin
			busy <= 1'b1;
			count <= '0;
		end else if (out_valid && out_ready) begin
			if (count == lpc_pkg::N_OUT_WORDS - 1)
				busy <= 1'b0;
			else
				count <= count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (res_valid && res_ready)
			snap <= result;
	end

endmodule

`default_nettype wire

// File: src/levinson_durbin_top.sv
`timescale 1ns/100ps
`default_nettype none

module levinson_durbin_top (
	input logic clock,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic signed [lpc_pkg::WORD_W-1:0] in_data,
	output logic out_valid,
	input logic out_ready,
	output lpc_pkg::out_word_t out_data
);

	logic frame_valid;
	logic frame_ready;
	lpc_pkg::lag_frame_t frame;

	logic div_start;
	logic div_done;
	logic [lpc_pkg::WORD_W-1:0] dividend;
	logic [lpc_pkg::WORD_W-1:0] divisor;
	logic [lpc_pkg::WORD_W-1:0] quotient;

	logic [lpc_pkg::LAG_IDX_W-1:0] rd_idx_a;
	logic [lpc_pkg::LAG_IDX_W-1:0] rd_idx_b;
	logic signed [lpc_pkg::WORD_W-1:0] rd_data_a;
	logic signed [lpc_pkg::WORD_W-1:0] rd_data_b;
	lpc_pkg::coef_wr_t coef_wr;
	logic step_commit;
	logic frame_begin;
	logic frame_end;
	logic frame_stable;
	logic rc_wr_en;
	logic rc_idx;
	logic signed [lpc_pkg::WORD_W-1:0] rc_value;

	logic res_valid;
	logic res_ready;
	lpc_pkg::lpc_result_t result;

	ld_input_buffer u_input_buffer (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.frame_valid(frame_valid),
		.frame_ready(frame_ready),
		.frame(frame)
	);

	ld_recursion_ctrl u_ctrl (
		.clock(clock),
		.reset(reset),
		.frame_valid(frame_valid),
		.frame_ready(frame_ready),
		.frame(frame),
		.div_start(div_start),
		.dividend(dividend),
		.divisor(divisor),
		.div_done(div_done),
		.quotient(quotient),
		.rd_idx_a(rd_idx_a),
		.rd_idx_b(rd_idx_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.coef_wr(coef_wr),
		.step_commit(step_commit),
		.frame_begin(frame_begin),
		.frame_end(frame_end),
		.frame_stable(frame_stable),
		.rc_wr_en(rc_wr_en),
		.rc_idx(rc_idx),
		.rc_value(rc_value),
		.res_valid(res_valid),
		.res_ready(res_ready)
	);

	q31_divider u_divider (
		.clock(clock),
		.reset(reset),
		.start(div_start),
		.dividend(dividend),
		.divisor(divisor),
		.done(div_done),
		.quotient(quotient)
	);

	ld_coef_bank u_coef_bank (
		.clock(clock),
		.reset(reset),
		.rd_idx_a(rd_idx_a),
		.rd_idx_b(rd_idx_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.coef_wr(coef_wr),
		.step_commit(step_commit),
		.frame_begin(frame_begin),
		.frame_end(frame_end),
		.frame_stable(frame_stable),
		.rc_wr_en(rc_wr_en),
		.rc_idx(rc_idx),
		.rc_value(rc_value),
		.result(result)
	);

	ld_output_stream u_output_stream (
		.clock(clock),
		.reset(reset),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.result(result),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

endmodule

`default_nettype wire

// File: tb/ld_ref_model.svh
`ifndef LD_REF_MODEL_SVH
`define LD_REF_MODEL_SVH

// Last stable result, the fallback for an unstable frame
lpc_pkg::lpc_result_t model_last_good;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

function automatic longint wrap32(input longint value);
	return longint'(int'(value));
endfunction

function automatic void reset_model();
	model_last_good = '0;
	model_last_good.a[0] = lpc_pkg::A0_ONE;
endfunction

////////////////////////////////////////
// One frame of the order recursion
////////////////////////////////////////

function automatic lpc_pkg::lpc_result_t ld_model_frame(input lpc_pkg::lag_frame_t fr);
	longint r [lpc_pkg::N_LAGS];
	longint a [lpc_pkg::N_LAGS];
	longint a_next [lpc_pkg::N_LAGS];
	longint k_first [lpc_pkg::N_RC_OUT];
	longint sat_max;
	longint alpha;
	longint acc;
	longint t;
	longint abs_t;
	longint q;
	longint k;
	longint ksq;
	longint rounded;
	bit stable;
	lpc_pkg::lpc_result_t res;

	sat_max = (longint'(1) <<< 31) - 1;
	for (int j = 0; j < lpc_pkg::N_LAGS; j++) begin
		r[j] = longint'($signed(fr.r[j]));
		a[j] = 0;
	end
	for (int m = 0; m < lpc_pkg::N_RC_OUT; m++)
		k_first[m] = 0;
	a[0] = longint'(1) <<< lpc_pkg::COEF_FRAC;
	alpha = r[0];
	stable = 1'b1;

	for (int i = 1; i <= lpc_pkg::LPC_ORDER && stable; i++) begin
		acc = r[i] <<< lpc_pkg::COEF_FRAC;
		for (int j = 1; j < i; j++)
			acc += r[j] * a[i - j];
		t = acc >>> lpc_pkg::COEF_FRAC;
		if (t > sat_max)
			t = sat_max;
		else if (t < -sat_max - 1)
			t = -sat_max - 1;
		abs_t = (t < 0) ? -t : t;
		if (abs_t >= alpha) begin
			stable = 1'b0;
		end else begin
			q = (abs_t <<< 31) / alpha;
			k = (t > 0) ? -q : q;
			if (q > longint'(lpc_pkg::K_LIMIT)) begin
				stable = 1'b0;
			end else begin
				if (i <= lpc_pkg::N_RC_OUT)
					k_first[i - 1] = k;
				a_next = a;
				for (int j = 1; j < i; j++)
					a_next[j] = wrap32(a[j] + ((k * a[i - j]) >>> 31));
				a_next[i] = k >>> (31 - lpc_pkg::COEF_FRAC);
				ksq = wrap32((k * k) >>> 31);
				alpha = wrap32(alpha - ((alpha * ksq) >>> 31));
				a = a_next;
			end
		end
	end

	if (stable) begin
		res = '0;
		res.a[0] = lpc_pkg::A0_ONE;
		for (int j = 1; j < lpc_pkg::N_LAGS; j++) begin
			rounded = (a[j] + (longint'(1) <<< 14)) >>> (lpc_pkg::COEF_FRAC - lpc_pkg::OUT_FRAC);
			res.a[j] = 16'(rounded);
		end
		for (int m = 0; m < lpc_pkg::N_RC_OUT; m++)
			res.rc[m] = 16'(k_first[m] >>> 16);
		model_last_good = res;
	end else begin
		res = model_last_good;
	end
	return res;
endfunction

`endif

// File: tb/tb_levinson.sv
`timescale 1ns/100ps
`default_nettype none

module tb_levinson;

	localparam int TIMEOUT_CYCLES = 4000;
	localparam logic [31:0] LFSR_SEED = 32'h45f0;
	localparam logic [31:0] R0_FULL = 32'h4000_0000;

	logic clock;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic signed [lpc_pkg::WORD_W-1:0] in_data;
	logic out_valid;
	logic out_ready;
	lpc_pkg::out_word_t out_data;

	logic [31:0] data_lfsr;
	logic [31:0] gate_lfsr;
	int check_count;
	int error_count;
	int test_count;
	int failed_tests;

	`include "ld_ref_model.svh"

	levinson_durbin_top u_dut (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int b = 0; b < count; b++) begin
			data_lfsr = lfsr_step(data_lfsr);
			bits = {bits[30:0], data_lfsr[0]};
		end
		return bits;
	endfunction

	function automatic logic gate_bit();
		gate_lfsr = lfsr_step(gate_lfsr);
		return gate_lfsr[0];
	endfunction

	// r[0] at 0.5, other lags well below it
	function automatic lpc_pkg::lag_frame_t random_frame();
		lpc_pkg::lag_frame_t fr;
		logic [31:0] mag;
		fr.r[0] = R0_FULL;
		for (int j = 1; j < lpc_pkg::N_LAGS; j++) begin
			mag = take_bits(24);
			if (take_bits(1) != 0)
				fr.r[j] = -mag;
			else
				fr.r[j] = mag;
		end
		return fr;
	endfunction

	function automatic lpc_pkg::out_word_t expected_word(input lpc_pkg::lpc_result_t res,
			input int n);
		lpc_pkg::out_word_t word;
		int m;
		m = n - lpc_pkg::N_LAGS;
		if (n < lpc_pkg::N_LAGS) begin
			word.is_rc = 1'b0;
			word.idx = n[lpc_pkg::LAG_IDX_W-1:0];
			word.value = res.a[n];
		end else begin
			word.is_rc = 1'b1;
			word.idx = m[lpc_pkg::LAG_IDX_W-1:0];
			word.value = res.rc[m];
		end
		return word;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
		$display("Test failed");
		$finish;
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("%s: pass", name);
		end else begin
			failed_tests++;
			$display("%s: %0d mismatches", name, error_count - errors_before);
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		in_valid = 1'b0;
		out_ready = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		reset_model();
	endtask

	////////////////////////////////////////
	// Stream drivers
	////////////////////////////////////////

	// Entered and left 1 ns after a rising edge
	task automatic send_frame(input lpc_pkg::lag_frame_t fr, input bit gaps);
		int n;
		int idle;
		bit accepted;
		n = 0;
		idle = 0;
		while (n < lpc_pkg::N_LAGS) begin
			in_valid = gaps ? (take_bits(2) != 0) : 1'b1;
			in_data = fr.r[n];
			#2;
			accepted = in_valid && in_ready;
			@(posedge clock);
			#1;
			if (accepted) begin
				n++;
				idle = 0;
			end else begin
				idle++;
				if (idle > TIMEOUT_CYCLES)
					abort_on_timeout("an input word to be accepted");
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic collect_frame(input string name, input lpc_pkg::lpc_result_t res,
			input bit gated);
		int n;
		int idle;
		bit taken;
		lpc_pkg::out_word_t word;
		n = 0;
		idle = 0;
		while (n < lpc_pkg::N_OUT_WORDS) begin
			out_ready = gated ? gate_bit() : 1'b1;
			#2;
			taken = out_valid && out_ready;
			word = out_data;
			@(posedge clock);
			#1;
			if (taken) begin
				check_value($sformatf("%s word %0d", name, n), expected_word(res, n), word);
				n++;
				idle = 0;
			end else begin
				idle++;
				if (idle > TIMEOUT_CYCLES)
					abort_on_timeout("an output word");
			end
		end
		out_ready = 1'b0;
	endtask

	// Output must stay quiet once every frame is read
	task automatic expect_no_extra_words(input string name, input int cycles);
		int extra;
		extra = 0;
		out_ready = 1'b1;
		for (int c = 0; c < cycles; c++) begin
			#2;
			if (out_valid)
				extra++;
			@(posedge clock);
			#1;
		end
		out_ready = 1'b0;
		check_value({name, " extra words"}, 0, extra);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic single_stable_frame();
		lpc_pkg::lag_frame_t fr;
		lpc_pkg::lpc_result_t res;
		int errors_before;
		errors_before = error_count;
		fr = '0;
		fr.r[0] = R0_FULL;
		fr.r[1] = 32'h2000_0000;
		res = ld_model_frame(fr);
		send_frame(fr, 1'b0);
		collect_frame("single_stable", res, 1'b0);
		report_test("single_stable", errors_before);
	endtask

	task automatic random_frames_back_to_back();
		lpc_pkg::lag_frame_t frames [4];
		lpc_pkg::lpc_result_t results [4];
		int errors_before;
		errors_before = error_count;
		for (int f = 0; f < 4; f++) begin
			frames[f] = random_frame();
			results[f] = ld_model_frame(frames[f]);
		end
		fork
			begin
				for (int f = 0; f < 4; f++)
					send_frame(frames[f], 1'b0);
			end
			begin
				for (int g = 0; g < 4; g++)
					collect_frame($sformatf("back_to_back frame %0d", g), results[g], 1'b0);
			end
		join
		expect_no_extra_words("back_to_back", 32);
		report_test("back_to_back", errors_before);
	endtask

	task automatic fallback_to_default();
		lpc_pkg::lag_frame_t fr;
		lpc_pkg::lpc_result_t res;
		int errors_before;
		errors_before = error_count;
		apply_reset();
		res = '0;
		res.a[0] = lpc_pkg::A0_ONE;
		// |r[1]| equal to r[0] fails at order 1
		fr = '0;
		fr.r[0] = R0_FULL;
		fr.r[1] = R0_FULL;
		void'(ld_model_frame(fr));
		send_frame(fr, 1'b0);
		collect_frame("unstable_after_reset", res, 1'b0);
		report_test("unstable_after_reset", errors_before);
	endtask

	task automatic fallback_to_last_stable();
		lpc_pkg::lag_frame_t good;
		lpc_pkg::lag_frame_t bad;
		lpc_pkg::lpc_result_t good_res;
		int errors_before;
		errors_before = error_count;
		good = random_frame();
		good_res = ld_model_frame(good);
		send_frame(good, 1'b0);
		collect_frame("unstable_after_stable good", good_res, 1'b0);
		// Passes order 1 with k = 0, fails at order 2
		bad = '0;
		bad.r[0] = R0_FULL;
		bad.r[2] = R0_FULL;
		void'(ld_model_frame(bad));
		send_frame(bad, 1'b0);
		collect_frame("unstable_after_stable repeat", good_res, 1'b0);
		report_test("unstable_after_stable", errors_before);
	endtask

	task automatic backpressure_and_gaps();
		lpc_pkg::lag_frame_t frames [3];
		lpc_pkg::lpc_result_t results [3];
		int errors_before;
		errors_before = error_count;
		for (int f = 0; f < 3; f++) begin
			frames[f] = random_frame();
			results[f] = ld_model_frame(frames[f]);
		end
		fork
			begin
				for (int f = 0; f < 3; f++)
					send_frame(frames[f], 1'b1);
			end
			begin
				for (int g = 0; g < 3; g++)
					collect_frame($sformatf("backpressure frame %0d", g), results[g], 1'b1);
			end
		join
		expect_no_extra_words("backpressure", 32);
		report_test("backpressure", errors_before);
	endtask

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		data_lfsr = LFSR_SEED;
		gate_lfsr = LFSR_SEED;
		check_count = 0;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		apply_reset();

		single_stable_frame();
		random_frames_back_to_back();
		fallback_to_default();
		fallback_to_last_stable();
		backpressure_and_gaps();

		$display("Tests run %0d, tests with errors %0d, checks %0d, mismatches %0d",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+tb
src/lpc_pkg.sv
src/ld_input_buffer.sv
src/q31_divider.sv
src/ld_coef_bank.sv
src/ld_recursion_ctrl.sv
src/ld_output_stream.sv
src/levinson_durbin_top.sv
tb/tb_levinson.sv

// File: run_sim.sh
#!/bin/sh
# Build the Levinson-Durbin testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_levinson \
	-f filelist.f \
	-o tb_levinson

./obj_dir/tb_levinson > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

echo "Simulation finished without a reported failure"
exit 0
